//--- logic/bitmanip_config.svh
// bitmanip configuration: datapath width and pipeline depth
`ifndef BITMANIP_CONFIG_SVH
`define BITMANIP_CONFIG_SVH

// integer datapath width
`define XLEN_W 64

// cycles from input strobe to result strobe
`define BITMANIP_LATENCY 2

`endif

//--- logic/bitmanip_pkg.sv
// bitmanip package: operand type, ALU opcodes and major opcodes
`default_nettype none

`include "bitmanip_config.svh"

package bitmanip_pkg;

  typedef logic [`XLEN_W-1:0] xlen_t;

  typedef enum logic [5:0] {
    OP_NONE,
    OP_UNSIGND_ADD_32, OP_AND_INV,
    OP_CARRY_LESS_MUL, OP_CARRY_LESS_MULH, OP_CARRY_LESS_MULR,
    OP_CLZ, OP_CLZW, OP_CPOP, OP_CPOPW, OP_CTZ, OP_CTZW,
    OP_SIGNED_MAX, OP_UNSIGNED_MAX, OP_SIGNED_MIN, OP_UNSIGNED_MIN,
    OP_BITWISE_OR, OP_INVERTED_OR, OP_BYTE_REVERSE,
    OP_ROTATE_LEFT, OP_ROTATE_LEFT_WORD, OP_ROTATE_RIGHT, OP_ROTATE_RIGHT_32,
    OP_BIT_CLEAR, OP_BIT_EXTRACT, OP_BIT_INVERT, OP_BIT_SET,
    OP_SIGN_EXTEND_8, OP_SIGN_EXTEND_16,
    OP_SIGNED_SH1ADD, OP_SIGNED_SH2ADD, OP_SIGNED_SH3ADD,
    OP_UNSIGNED_SH1ADD_32, OP_UNSIGNED_SH2ADD_32, OP_UNSIGNED_SH3ADD_32,
    OP_UNSIGNED_SHIFT_LEFT_32, OP_XNOR, OP_ZERO_EXTEND_16
  } op_t;

  // major opcodes that carry B-extension instructions
  typedef enum logic [6:0] {
    OP        = 7'b0110011,
    OP_32     = 7'b0111011,
    OP_IMM    = 7'b0010011,
    OP_IMM_32 = 7'b0011011
  } opcode_major_t;

endpackage

`default_nettype wire

//--- logic/bit_clz.sv
// bit_clz: leading-zero counter built as a halving priority tree
`timescale 1ns/1ps
`default_nettype none

module bit_clz #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0]        i_in,
  output logic [$clog2(WIDTH):0]  o_out
);

  localparam int LOG = $clog2(WIDTH);

  // level l nodes cover 2**l bits, count MSB set means the whole span is zero
  for (genvar l = 1; l <= LOG; l++) begin : g_lvl
    logic [l:0] w_cnt [WIDTH >> l];
    for (genvar n = 0; n < (WIDTH >> l); n++) begin : g_node
      if (l == 1) begin : g_leaf
        assign w_cnt[n] = {~i_in[2*n+1] & ~i_in[2*n], ~i_in[2*n+1] & i_in[2*n]};
      end else begin : g_merge
        logic [l-1:0] w_hi;
        logic [l-1:0] w_lo;
        assign w_hi = g_lvl[l-1].w_cnt[2*n+1];
        assign w_lo = g_lvl[l-1].w_cnt[2*n];
        // upper half all zero: add half the span to the lower count
        assign w_cnt[n] = w_hi[l-1] ? {w_lo[l-1], ~w_lo[l-1], w_lo[l-2:0]} : {1'b0, w_hi};
      end
    end
  end

  assign o_out = g_lvl[LOG].w_cnt[0];

endmodule

`default_nettype wire

//--- logic/bit_cnt.sv
// bit_cnt: population counter built as a binary adder tree
`timescale 1ns/1ps
`default_nettype none

module bit_cnt #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0]        i_in,
  output logic [$clog2(WIDTH):0]  o_out
);

  localparam int LOG = $clog2(WIDTH);

  for (genvar l = 1; l <= LOG; l++) begin : g_lvl
    logic [l:0] w_sum [WIDTH >> l];
    for (genvar n = 0; n < (WIDTH >> l); n++) begin : g_node
      if (l == 1) begin : g_leaf
        assign w_sum[n] = {1'b0, i_in[2*n+1]} + {1'b0, i_in[2*n]};
      end else begin : g_add
        assign w_sum[n] = {1'b0, g_lvl[l-1].w_sum[2*n+1]} + {1'b0, g_lvl[l-1].w_sum[2*n]};
      end
    end
  end

  assign o_out = g_lvl[LOG].w_sum[0];

endmodule

`default_nettype wire

//--- logic/bitmanip_alu.sv
// bitmanip_alu: combinational Zba/Zbb/Zbc/Zbs result datapath
`timescale 1ns/1ps
`default_nettype none

`include "bitmanip_config.svh"

module bitmanip_alu (
  input  bitmanip_pkg::xlen_t i_rs1,
  input  bitmanip_pkg::xlen_t i_rs2,
  input  bitmanip_pkg::op_t   i_op,
  output logic                o_valid,
  output bitmanip_pkg::xlen_t o_out
);

  import bitmanip_pkg::*;

  localparam int XLEN  = `XLEN_W;
  localparam int SHW   = $clog2(XLEN);
  localparam int CNT_W = SHW + 1;

  logic [SHW-1:0]    w_shamt;
  logic [4:0]        w_shamt_w;
  logic [31:0]       w_rolw;
  logic [31:0]       w_rorw;
  xlen_t             w_orc_b;
  xlen_t             w_rev8;
  xlen_t             w_rev_64;
  logic [31:0]       w_rev_32;
  logic [CNT_W-1:0]  w_clz_64;
  logic [CNT_W-1:0]  w_ctz_64;
  logic [CNT_W-1:0]  w_cpop_64;
  logic [5:0]        w_clz_32;
  logic [5:0]        w_ctz_32;
  logic [5:0]        w_cpop_32;
  logic [2*XLEN-1:0] w_pp [XLEN];
  logic [2*XLEN-1:0] w_clmul;

  assign w_shamt   = i_rs2[SHW-1:0];
  assign w_shamt_w = i_rs2[4:0];

  assign w_rolw = (i_rs1[31:0] << w_shamt_w) | (i_rs1[31:0] >> (32 - w_shamt_w));
  assign w_rorw = (i_rs1[31:0] >> w_shamt_w) | (i_rs1[31:0] << (32 - w_shamt_w));

  for (genvar b = 0; b < XLEN; b += 8) begin : g_byte
    assign w_orc_b[b +: 8] = {8{|i_rs1[b +: 8]}};
    assign w_rev8[b +: 8]  = i_rs1[XLEN-8-b +: 8];
  end

  // trailing zeros are leading zeros of the mirrored operand
  assign w_rev_64 = {<<{i_rs1}};
  assign w_rev_32 = {<<{i_rs1[31:0]}};

  bit_clz #(.WIDTH(XLEN)) u_clz_64 (.i_in(i_rs1),       .o_out(w_clz_64));
  bit_clz #(.WIDTH(32))   u_clz_32 (.i_in(i_rs1[31:0]), .o_out(w_clz_32));
  bit_clz #(.WIDTH(XLEN)) u_ctz_64 (.i_in(w_rev_64),    .o_out(w_ctz_64));
  bit_clz #(.WIDTH(32))   u_ctz_32 (.i_in(w_rev_32),    .o_out(w_ctz_32));
  bit_cnt #(.WIDTH(XLEN)) u_cnt_64 (.i_in(i_rs1),       .o_out(w_cpop_64));
  bit_cnt #(.WIDTH(32))   u_cnt_32 (.i_in(i_rs1[31:0]), .o_out(w_cpop_32));

  // carry-less product, one shifted copy of rs1 per set bit of rs2
  for (genvar p = 0; p < XLEN; p++) begin : g_pp
    assign w_pp[p] = i_rs2[p] ? ({{XLEN{1'b0}}, i_rs1} << p) : '0;
  end
  for (genvar c = 0; c < 2*XLEN; c++) begin : g_col
    logic [XLEN-1:0] w_col;
    for (genvar p = 0; p < XLEN; p++) begin : g_bit
      assign w_col[p] = w_pp[p][c];
    end
    assign w_clmul[c] = ^w_col;
  end

  always_comb begin
    o_valid = 1'b1;
    case (i_op)
      OP_UNSIGND_ADD_32:   o_out = {{(XLEN-32){1'b0}}, i_rs1[31:0]} + i_rs2;
      OP_AND_INV:          o_out = i_rs1 & ~i_rs2;
      OP_CARRY_LESS_MUL:   o_out = w_clmul[XLEN-1:0];
      OP_CARRY_LESS_MULH:  o_out = w_clmul[2*XLEN-1:XLEN];
      OP_CARRY_LESS_MULR:  o_out = w_clmul[2*XLEN-2:XLEN-1];
      OP_CLZ:              o_out = {{(XLEN-CNT_W){1'b0}}, w_clz_64};
      OP_CLZW:             o_out = {{(XLEN-6){1'b0}}, w_clz_32};
      OP_CPOP:             o_out = {{(XLEN-CNT_W){1'b0}}, w_cpop_64};
      OP_CPOPW:            o_out = {{(XLEN-6){1'b0}}, w_cpop_32};
      OP_CTZ:              o_out = {{(XLEN-CNT_W){1'b0}}, w_ctz_64};
      OP_CTZW:             o_out = {{(XLEN-6){1'b0}}, w_ctz_32};
      OP_SIGNED_MAX:       o_out = ($signed(i_rs1) > $signed(i_rs2)) ? i_rs1 : i_rs2;
      OP_UNSIGNED_MAX:     o_out = (i_rs1 > i_rs2) ? i_rs1 : i_rs2;
      OP_SIGNED_MIN:       o_out = ($signed(i_rs1) < $signed(i_rs2)) ? i_rs1 : i_rs2;
      OP_UNSIGNED_MIN:     o_out = (i_rs1 < i_rs2) ? i_rs1 : i_rs2;
      OP_BITWISE_OR:       o_out = w_orc_b;
      OP_INVERTED_OR:      o_out = i_rs1 | ~i_rs2;
      OP_BYTE_REVERSE:     o_out = w_rev8;
      OP_ROTATE_LEFT:      o_out = (i_rs1 << w_shamt) | (i_rs1 >> (XLEN - w_shamt));
      OP_ROTATE_LEFT_WORD: o_out = {{(XLEN-32){w_rolw[31]}}, w_rolw};
      OP_ROTATE_RIGHT:     o_out = (i_rs1 >> w_shamt) | (i_rs1 << (XLEN - w_shamt));
      OP_ROTATE_RIGHT_32:  o_out = {{(XLEN-32){w_rorw[31]}}, w_rorw};
      OP_BIT_CLEAR:        o_out = i_rs1 & ~(xlen_t'(1) << w_shamt);
      OP_BIT_EXTRACT:      o_out = {{(XLEN-1){1'b0}}, i_rs1[w_shamt]};
      OP_BIT_INVERT:       o_out = i_rs1 ^ (xlen_t'(1) << w_shamt);
      OP_BIT_SET:          o_out = i_rs1 | (xlen_t'(1) << w_shamt);
      OP_SIGN_EXTEND_8:    o_out = {{(XLEN-8){i_rs1[7]}}, i_rs1[7:0]};
      OP_SIGN_EXTEND_16:   o_out = {{(XLEN-16){i_rs1[15]}}, i_rs1[15:0]};
      OP_SIGNED_SH1ADD:    o_out = i_rs2 + {i_rs1[XLEN-2:0], 1'b0};
      OP_SIGNED_SH2ADD:    o_out = i_rs2 + {i_rs1[XLEN-3:0], 2'b00};
      OP_SIGNED_SH3ADD:    o_out = i_rs2 + {i_rs1[XLEN-4:0], 3'b000};
      OP_UNSIGNED_SH1ADD_32: o_out = i_rs2 + {{(XLEN-33){1'b0}}, i_rs1[31:0], 1'b0};
      OP_UNSIGNED_SH2ADD_32: o_out = i_rs2 + {{(XLEN-34){1'b0}}, i_rs1[31:0], 2'b00};
      OP_UNSIGNED_SH3ADD_32: o_out = i_rs2 + {{(XLEN-35){1'b0}}, i_rs1[31:0], 3'b000};
      OP_UNSIGNED_SHIFT_LEFT_32: o_out = {{(XLEN-32){1'b0}}, i_rs1[31:0]} << w_shamt;
      OP_XNOR:             o_out = ~(i_rs1 ^ i_rs2);
      OP_ZERO_EXTEND_16:   o_out = {{(XLEN-16){1'b0}}, i_rs1[15:0]};
      default: begin
        // OP_NONE: not a supported instruction
        o_valid = 1'b0;
        o_out   = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/bitmanip_decode_stage.sv
// bitmanip_decode_stage: instruction decode and operand register stage
`timescale 1ns/1ps
`default_nettype none

module bitmanip_decode_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  logic [31:0]         i_instr,
  input  bitmanip_pkg::xlen_t i_rs1,
  input  bitmanip_pkg::xlen_t i_rs2,
  output logic                o_valid,
  output bitmanip_pkg::op_t   o_op,
  output bitmanip_pkg::xlen_t o_rs1,
  output bitmanip_pkg::xlen_t o_rs2
);

  import bitmanip_pkg::*;

  opcode_major_t w_major;
  logic [9:0]    w_f7_f3;
  logic [11:0]   w_imm;
  logic [2:0]    w_funct3;
  logic          w_use_imm;
  op_t           w_op;
  xlen_t         w_rs2;

  assign w_major  = opcode_major_t'(i_instr[6:0]);
  assign w_funct3 = i_instr[14:12];
  assign w_f7_f3  = {i_instr[31:25], w_funct3};
  assign w_imm    = i_instr[31:20];

  always_comb begin
    w_op      = OP_NONE;
    w_use_imm = 1'b0;
    case (w_major)
      OP: begin
        case (w_f7_f3)
          10'b0100000_111: w_op = OP_AND_INV;
          10'b0100000_110: w_op = OP_INVERTED_OR;
          10'b0100000_100: w_op = OP_XNOR;
          10'b0000101_110: w_op = OP_SIGNED_MAX;
          10'b0000101_111: w_op = OP_UNSIGNED_MAX;
          10'b0000101_100: w_op = OP_SIGNED_MIN;
          10'b0000101_101: w_op = OP_UNSIGNED_MIN;
          10'b0000101_001: w_op = OP_CARRY_LESS_MUL;
          10'b0000101_010: w_op = OP_CARRY_LESS_MULR;
          10'b0000101_011: w_op = OP_CARRY_LESS_MULH;
          10'b0110000_001: w_op = OP_ROTATE_LEFT;
          10'b0110000_101: w_op = OP_ROTATE_RIGHT;
          10'b0100100_001: w_op = OP_BIT_CLEAR;
          10'b0100100_101: w_op = OP_BIT_EXTRACT;
          10'b0110100_001: w_op = OP_BIT_INVERT;
          10'b0010100_001: w_op = OP_BIT_SET;
          10'b0010000_010: w_op = OP_SIGNED_SH1ADD;
          10'b0010000_100: w_op = OP_SIGNED_SH2ADD;
          10'b0010000_110: w_op = OP_SIGNED_SH3ADD;
          default:         w_op = OP_NONE;
        endcase
      end
      OP_32: begin
        case (w_f7_f3)
          10'b0000100_000: w_op = OP_UNSIGND_ADD_32;
          10'b0010000_010: w_op = OP_UNSIGNED_SH1ADD_32;
          10'b0010000_100: w_op = OP_UNSIGNED_SH2ADD_32;
          10'b0010000_110: w_op = OP_UNSIGNED_SH3ADD_32;
          10'b0110000_001: w_op = OP_ROTATE_LEFT_WORD;
          10'b0110000_101: w_op = OP_ROTATE_RIGHT_32;
          // zext.h also needs rs2 field zero
          10'b0000100_100: w_op = (i_instr[24:20] == 5'd0) ? OP_ZERO_EXTEND_16 : OP_NONE;
          default:         w_op = OP_NONE;
        endcase
      end
      OP_IMM: begin
        casez ({w_funct3, w_imm})
          15'b001_011000000000: w_op = OP_CLZ;
          15'b001_011000000001: w_op = OP_CTZ;
          15'b001_011000000010: w_op = OP_CPOP;
          15'b001_011000000100: w_op = OP_SIGN_EXTEND_8;
          15'b001_011000000101: w_op = OP_SIGN_EXTEND_16;
          15'b101_001010000111: w_op = OP_BITWISE_OR;
          15'b101_011010111000: w_op = OP_BYTE_REVERSE;
          15'b001_010010??????: {w_op, w_use_imm} = {OP_BIT_CLEAR, 1'b1};
          15'b001_001010??????: {w_op, w_use_imm} = {OP_BIT_SET, 1'b1};
          15'b001_011010??????: {w_op, w_use_imm} = {OP_BIT_INVERT, 1'b1};
          15'b101_010010??????: {w_op, w_use_imm} = {OP_BIT_EXTRACT, 1'b1};
          15'b101_011000??????: {w_op, w_use_imm} = {OP_ROTATE_RIGHT, 1'b1};
          default:              w_op = OP_NONE;
        endcase
      end
      OP_IMM_32: begin
        casez ({w_funct3, w_imm})
          15'b001_011000000000: w_op = OP_CLZW;
          15'b001_011000000001: w_op = OP_CTZW;
          15'b001_011000000010: w_op = OP_CPOPW;
          15'b101_0110000?????: {w_op, w_use_imm} = {OP_ROTATE_RIGHT_32, 1'b1};
          15'b001_000010??????: {w_op, w_use_imm} = {OP_UNSIGNED_SHIFT_LEFT_32, 1'b1};
          default:              w_op = OP_NONE;
        endcase
      end
      default: w_op = OP_NONE;
    endcase
  end

  // immediate forms take the zero-extended shamt as the second operand
  assign w_rs2 = w_use_imm ? {{($bits(xlen_t)-6){1'b0}}, i_instr[25:20]} : i_rs2;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_op  <= w_op;
      o_rs1 <= i_rs1;
      o_rs2 <= w_rs2;
    end
  end

endmodule

`default_nettype wire

//--- logic/bitmanip_execute_stage.sv
// bitmanip_execute_stage: ALU evaluation and result register stage
`timescale 1ns/1ps
`default_nettype none

module bitmanip_execute_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  bitmanip_pkg::op_t   i_op,
  input  bitmanip_pkg::xlen_t i_rs1,
  input  bitmanip_pkg::xlen_t i_rs2,
  output logic                o_valid,
  output logic                o_illegal,
  output bitmanip_pkg::xlen_t o_result
);

  import bitmanip_pkg::*;

  logic  w_alu_valid;
  xlen_t w_alu_out;

  bitmanip_alu u_alu (
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .i_op    (i_op),
    .o_valid (w_alu_valid),
    .o_out   (w_alu_out)
  );

  // result and flag hold their value between valid slots
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
      o_result  <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_illegal <= ~w_alu_valid;
        o_result  <= w_alu_out;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/bitmanip_unit.sv
// bitmanip_unit: two-stage bit-manipulation execution unit top level
`timescale 1ns/1ps
`default_nettype none

module bitmanip_unit (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  logic [31:0]         i_instr,
  input  bitmanip_pkg::xlen_t i_rs1,
  input  bitmanip_pkg::xlen_t i_rs2,
  output logic                o_valid,
  output logic                o_illegal,
  output bitmanip_pkg::xlen_t o_result
);

  import bitmanip_pkg::*;

  // decode to execute
  logic  w_ex_valid;
  op_t   w_ex_op;
  xlen_t w_ex_rs1;
  xlen_t w_ex_rs2;

  bitmanip_decode_stage u_decode (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .i_instr  (i_instr),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .o_valid  (w_ex_valid),
    .o_op     (w_ex_op),
    .o_rs1    (w_ex_rs1),
    .o_rs2    (w_ex_rs2)
  );

  bitmanip_execute_stage u_execute (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (w_ex_valid),
    .i_op      (w_ex_op),
    .i_rs1     (w_ex_rs1),
    .i_rs2     (w_ex_rs2),
    .o_valid   (o_valid),
    .o_illegal (o_illegal),
    .o_result  (o_result)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// tb_clock: free-running testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

//--- dv/bitmanip_assertions.sv
// bitmanip_assertions: concurrent checks on the bitmanip_unit output strobe
`timescale 1ns/1ps
`default_nettype none

`include "bitmanip_config.svh"

module bitmanip_assertions (
  input logic                i_clk,
  input logic                i_arst_n,
  input logic                i_valid,
  input logic                o_valid,
  input logic                o_illegal,
  input bitmanip_pkg::xlen_t o_result
);

  // outputs quiet on the first edge after reset release
  a_reset_quiet: assert property (@(posedge i_clk)
    $rose(i_arst_n) |-> (!o_valid && !o_illegal))
    else $error("outputs active on first edge after reset");

  // an illegal flag only rises with a result slot
  a_illegal_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(o_illegal) |-> o_valid)
    else $error("illegal flag raised without valid");

  a_illegal_zero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_valid && o_illegal) |-> (o_result == '0))
    else $error("illegal slot carries nonzero result");

  a_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_valid |-> ##(`BITMANIP_LATENCY) o_valid)
    else $error("valid input not followed by valid output");

endmodule

bind bitmanip_unit bitmanip_assertions u_assertions (
  .i_clk     (i_clk),
  .i_arst_n  (i_arst_n),
  .i_valid   (i_valid),
  .o_valid   (o_valid),
  .o_illegal (o_illegal),
  .o_result  (o_result)
);

`default_nettype wire

//--- dv/bitmanip_tb.sv
// bitmanip_tb: directed tests for the two-stage bit-manipulation unit
`timescale 1ns/1ps
`default_nettype none

`include "bitmanip_config.svh"

module bitmanip_tb;

  import bitmanip_pkg::*;

  localparam int LAT = `BITMANIP_LATENCY;
  // about 140 issued words plus drains and reset with margin
  localparam int MAX_CYCLES = 400;

  logic        clk;
  logic        arst_n;
  logic        valid;
  logic [31:0] instr;
  xlen_t       rs1;
  xlen_t       rs2;
  logic        o_valid;
  logic        o_illegal;
  xlen_t       o_result;

  int    seed = 32'h37d0;
  int    cyc = 0;
  int    clk_count = 0;
  int    errors = 0;
  int    tests_ok = 0;
  int    tests_bad = 0;
  string cur_test;

  // expected responses in issue order
  xlen_t exp_res [$];
  logic  exp_ill [$];
  int    exp_due [$];

  tb_clock #(.PERIOD_NS(40)) u_clock (.o_clk(clk));

  bitmanip_unit dut (
    .i_clk     (clk),
    .i_arst_n  (arst_n),
    .i_valid   (valid),
    .i_instr   (instr),
    .i_rs1     (rs1),
    .i_rs2     (rs2),
    .o_valid   (o_valid),
    .o_illegal (o_illegal),
    .o_result  (o_result)
  );

  always @(posedge clk) begin
    clk_count++;
    if (clk_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(opcode_major_t major, logic [6:0] f7, logic [2:0] f3);
    return {f7, 5'd3, 5'd2, f3, 5'd1, major};
  endfunction

  function automatic logic [31:0] enc_i(opcode_major_t major, logic [11:0] imm, logic [2:0] f3);
    return {imm, 5'd2, f3, 5'd1, major};
  endfunction

  function automatic logic [31:0] encode_reg(op_t op);
    case (op)
      OP_CLZ:                return enc_i(OP_IMM, 12'h600, 3'b001);
      OP_CTZ:                return enc_i(OP_IMM, 12'h601, 3'b001);
      OP_CPOP:               return enc_i(OP_IMM, 12'h602, 3'b001);
      OP_SIGN_EXTEND_8:      return enc_i(OP_IMM, 12'h604, 3'b001);
      OP_SIGN_EXTEND_16:     return enc_i(OP_IMM, 12'h605, 3'b001);
      OP_BITWISE_OR:         return enc_i(OP_IMM, 12'h287, 3'b101);
      OP_BYTE_REVERSE:       return enc_i(OP_IMM, 12'h6b8, 3'b101);
      OP_CLZW:               return enc_i(OP_IMM_32, 12'h600, 3'b001);
      OP_CTZW:               return enc_i(OP_IMM_32, 12'h601, 3'b001);
      OP_CPOPW:              return enc_i(OP_IMM_32, 12'h602, 3'b001);
      OP_ZERO_EXTEND_16:     return enc_i(OP_32, 12'h080, 3'b100);
      OP_AND_INV:            return enc_r(OP, 7'b0100000, 3'b111);
      OP_INVERTED_OR:        return enc_r(OP, 7'b0100000, 3'b110);
      OP_XNOR:               return enc_r(OP, 7'b0100000, 3'b100);
      OP_SIGNED_MAX:         return enc_r(OP, 7'b0000101, 3'b110);
      OP_UNSIGNED_MAX:       return enc_r(OP, 7'b0000101, 3'b111);
      OP_SIGNED_MIN:         return enc_r(OP, 7'b0000101, 3'b100);
      OP_UNSIGNED_MIN:       return enc_r(OP, 7'b0000101, 3'b101);
      OP_CARRY_LESS_MUL:     return enc_r(OP, 7'b0000101, 3'b001);
      OP_CARRY_LESS_MULR:    return enc_r(OP, 7'b0000101, 3'b010);
      OP_CARRY_LESS_MULH:    return enc_r(OP, 7'b0000101, 3'b011);
      OP_ROTATE_LEFT:        return enc_r(OP, 7'b0110000, 3'b001);
      OP_ROTATE_RIGHT:       return enc_r(OP, 7'b0110000, 3'b101);
      OP_BIT_CLEAR:          return enc_r(OP, 7'b0100100, 3'b001);
      OP_BIT_EXTRACT:        return enc_r(OP, 7'b0100100, 3'b101);
      OP_BIT_INVERT:         return enc_r(OP, 7'b0110100, 3'b001);
      OP_BIT_SET:            return enc_r(OP, 7'b0010100, 3'b001);
      OP_SIGNED_SH1ADD:      return enc_r(OP, 7'b0010000, 3'b010);
      OP_SIGNED_SH2ADD:      return enc_r(OP, 7'b0010000, 3'b100);
      OP_SIGNED_SH3ADD:      return enc_r(OP, 7'b0010000, 3'b110);
      OP_UNSIGND_ADD_32:     return enc_r(OP_32, 7'b0000100, 3'b000);
      OP_UNSIGNED_SH1ADD_32: return enc_r(OP_32, 7'b0010000, 3'b010);
      OP_UNSIGNED_SH2ADD_32: return enc_r(OP_32, 7'b0010000, 3'b100);
      OP_UNSIGNED_SH3ADD_32: return enc_r(OP_32, 7'b0010000, 3'b110);
      OP_ROTATE_LEFT_WORD:   return enc_r(OP_32, 7'b0110000, 3'b001);
      OP_ROTATE_RIGHT_32:    return enc_r(OP_32, 7'b0110000, 3'b101);
      default:               return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] encode_imm(op_t op, logic [5:0] sh);
    case (op)
      OP_ROTATE_RIGHT:    return enc_i(OP_IMM, {6'b011000, sh}, 3'b101);
      OP_ROTATE_RIGHT_32: return enc_i(OP_IMM_32, {7'b0110000, sh[4:0]}, 3'b101);
      OP_BIT_CLEAR:       return enc_i(OP_IMM, {6'b010010, sh}, 3'b001);
      OP_BIT_SET:         return enc_i(OP_IMM, {6'b001010, sh}, 3'b001);
      OP_BIT_INVERT:      return enc_i(OP_IMM, {6'b011010, sh}, 3'b001);
      OP_BIT_EXTRACT:     return enc_i(OP_IMM, {6'b010010, sh}, 3'b101);
      OP_UNSIGNED_SHIFT_LEFT_32: return enc_i(OP_IMM_32, {6'b000010, sh}, 3'b001);
      default:            return 32'h0;
    endcase
  endfunction

  // expected result straight from the instruction definitions
  function automatic xlen_t model(op_t op, xlen_t a, xlen_t b);
    xlen_t        r;
    logic [127:0] prod;
    logic [31:0]  w;
    int           n;
    int           sh;
    int           shw;
    r   = '0;
    w   = '0;
    sh  = int'(b[5:0]);
    shw = int'(b[4:0]);
    case (op)
      OP_CLZ: begin
        n = 0;
        while (n < 64 && !a[63-n]) n++;
        r = xlen_t'(n);
      end
      OP_CLZW: begin
        n = 0;
        while (n < 32 && !a[31-n]) n++;
        r = xlen_t'(n);
      end
      OP_CTZ: begin
        n = 0;
        while (n < 64 && !a[n]) n++;
        r = xlen_t'(n);
      end
      OP_CTZW: begin
        n = 0;
        while (n < 32 && !a[n]) n++;
        r = xlen_t'(n);
      end
      OP_CPOP:  r = xlen_t'($countones(a));
      OP_CPOPW: r = xlen_t'($countones(a[31:0]));
      OP_AND_INV:     r = a & ~b;
      OP_INVERTED_OR: r = a | ~b;
      OP_XNOR:        r = ~(a ^ b);
      OP_BITWISE_OR: begin
        for (n = 0; n < 8; n++) r[8*n +: 8] = (a[8*n +: 8] != 8'h0) ? 8'hff : 8'h00;
      end
      OP_BYTE_REVERSE: begin
        for (n = 0; n < 8; n++) r[8*n +: 8] = a[56-8*n +: 8];
      end
      OP_SIGN_EXTEND_8:  r = {{56{a[7]}}, a[7:0]};
      OP_SIGN_EXTEND_16: r = {{48{a[15]}}, a[15:0]};
      OP_ZERO_EXTEND_16: r = {48'h0, a[15:0]};
      OP_SIGNED_MAX:   r = ($signed(a) > $signed(b)) ? a : b;
      OP_SIGNED_MIN:   r = ($signed(a) < $signed(b)) ? a : b;
      OP_UNSIGNED_MAX: r = (a > b) ? a : b;
      OP_UNSIGNED_MIN: r = (a < b) ? a : b;
      OP_ROTATE_LEFT: begin
        for (n = 0; n < 64; n++) r[(n + sh) % 64] = a[n];
      end
      OP_ROTATE_RIGHT: begin
        for (n = 0; n < 64; n++) r[n] = a[(n + sh) % 64];
      end
      OP_ROTATE_LEFT_WORD: begin
        for (n = 0; n < 32; n++) w[(n + shw) % 32] = a[n];
        r = {{32{w[31]}}, w};
      end
      OP_ROTATE_RIGHT_32: begin
        for (n = 0; n < 32; n++) w[n] = a[(n + shw) % 32];
        r = {{32{w[31]}}, w};
      end
      OP_BIT_CLEAR: begin
        r = a;
        r[sh] = 1'b0;
      end
      OP_BIT_SET: begin
        r = a;
        r[sh] = 1'b1;
      end
      OP_BIT_INVERT: begin
        r = a;
        r[sh] = ~a[sh];
      end
      OP_BIT_EXTRACT:        r = {63'h0, a[sh]};
      OP_SIGNED_SH1ADD:      r = b + (a << 1);
      OP_SIGNED_SH2ADD:      r = b + (a << 2);
      OP_SIGNED_SH3ADD:      r = b + (a << 3);
      OP_UNSIGND_ADD_32:     r = b + {32'h0, a[31:0]};
      OP_UNSIGNED_SH1ADD_32: r = b + ({32'h0, a[31:0]} << 1);
      OP_UNSIGNED_SH2ADD_32: r = b + ({32'h0, a[31:0]} << 2);
      OP_UNSIGNED_SH3ADD_32: r = b + ({32'h0, a[31:0]} << 3);
      OP_UNSIGNED_SHIFT_LEFT_32: r = {32'h0, a[31:0]} << sh;
      OP_CARRY_LESS_MUL, OP_CARRY_LESS_MULH, OP_CARRY_LESS_MULR: begin
        prod = '0;
        for (n = 0; n < 64; n++) begin
          if (b[n]) prod = prod ^ ({64'h0, a} << n);
        end
        if (op == OP_CARRY_LESS_MUL) r = prod[63:0];
        else if (op == OP_CARRY_LESS_MULH) r = prod[127:64];
        else r = prod[126:63];
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic xlen_t rand64();
    xlen_t v;
    v = {$random(seed), $random(seed)};
    return v;
  endfunction

  task automatic check_result(string what, xlen_t exp, xlen_t act);
    if (exp !== act) begin
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("FAIL %s %s expected %b actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // advance one clock and sample the outputs once stable
  task automatic step();
    logic due;
    @(posedge clk);
    #2;
    cyc++;
    due = (exp_due.size() > 0) && (exp_due[0] == cyc);
    check_flag("o_valid", due, o_valid);
    if (due) begin
      check_result("o_result", exp_res.pop_front(), o_result);
      check_flag("o_illegal", exp_ill.pop_front(), o_illegal);
      void'(exp_due.pop_front());
    end
  endtask

  task automatic issue_word(logic [31:0] ins, xlen_t a, xlen_t b, xlen_t exp, logic ill);
    valid = 1'b1;
    instr = ins;
    rs1   = a;
    rs2   = b;
    exp_res.push_back(exp);
    exp_ill.push_back(ill);
    exp_due.push_back(cyc + LAT);
    step();
  endtask

  task automatic issue_reg(op_t op, xlen_t a, xlen_t b);
    issue_word(encode_reg(op), a, b, model(op, a, b), 1'b0);
  endtask

  // rs2 carries noise that the decoder must replace with the shamt
  task automatic issue_imm(op_t op, xlen_t a, logic [5:0] sh);
    issue_word(encode_imm(op, sh), a, rand64(), model(op, a, xlen_t'(sh)), 1'b0);
  endtask

  task automatic finish_test();
    valid = 1'b0;
    repeat (LAT + 1) step();
    if (exp_due.size() != 0) begin
      $display("%s: results still outstanding after drain", cur_test);
      errors++;
    end
  endtask

  task automatic run_test(int id);
    int e0;
    e0 = errors;
    case (id)
      1: test_reset();
      2: test_zbb();
      3: test_rotate();
      4: test_zbs_zba();
      5: test_clmul();
      default: test_stream();
    endcase
    finish_test();
    if (errors == e0) begin
      $display("test %s: ok", cur_test);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", cur_test, errors - e0);
      tests_bad++;
    end
  endtask

  task automatic test_reset();
    cur_test = "reset";
    repeat (3) begin
      step();
      check_flag("o_illegal", 1'b0, o_illegal);
      check_result("o_result", '0, o_result);
    end
  endtask

  task automatic test_zbb();
    op_t   ops [19];
    xlen_t a;
    xlen_t b;
    cur_test = "zbb";
    ops = '{OP_CLZ, OP_CLZW, OP_CTZ, OP_CTZW, OP_CPOP, OP_CPOPW, OP_AND_INV,
            OP_INVERTED_OR, OP_XNOR, OP_BITWISE_OR, OP_BYTE_REVERSE, OP_SIGN_EXTEND_8,
            OP_SIGN_EXTEND_16, OP_ZERO_EXTEND_16, OP_SIGNED_MAX, OP_UNSIGNED_MAX,
            OP_SIGNED_MIN, OP_UNSIGNED_MIN, OP_XNOR};
    for (int k = 0; k < 4; k++) begin
      a = (k == 0) ? '0 : (k == 1) ? '1 : rand64();
      b = (k == 0) ? '1 : (k == 1) ? '0 : rand64();
      foreach (ops[i]) issue_reg(ops[i], a, b);
    end
  endtask

  task automatic test_rotate();
    logic [5:0] sh;
    xlen_t      a;
    cur_test = "rotate";
    for (int k = 0; k < 3; k++) begin
      sh = (k == 0) ? 6'd0 : (k == 1) ? 6'd31 : 6'($random(seed));
      a  = rand64();
      // bit 31 set makes the word forms sign-extend ones at shamt 0
      if (k == 0) a[31] = 1'b1;
      issue_reg(OP_ROTATE_LEFT, a, {58'h0, sh});
      issue_reg(OP_ROTATE_RIGHT, a, {58'h0, sh});
      issue_imm(OP_ROTATE_RIGHT, a, sh);
      issue_reg(OP_ROTATE_LEFT_WORD, a, {58'h0, sh});
      issue_reg(OP_ROTATE_RIGHT_32, a, {58'h0, sh});
      issue_imm(OP_ROTATE_RIGHT_32, a, {1'b0, sh[4:0]});
    end
  endtask

  task automatic test_zbs_zba();
    op_t        bits [4];
    op_t        adds [7];
    logic [5:0] sh;
    xlen_t      a;
    xlen_t      b;
    cur_test = "zbs_zba";
    bits = '{OP_BIT_CLEAR, OP_BIT_SET, OP_BIT_INVERT, OP_BIT_EXTRACT};
    adds = '{OP_SIGNED_SH1ADD, OP_SIGNED_SH2ADD, OP_SIGNED_SH3ADD, OP_UNSIGND_ADD_32,
             OP_UNSIGNED_SH1ADD_32, OP_UNSIGNED_SH2ADD_32, OP_UNSIGNED_SH3ADD_32};
    for (int k = 0; k < 2; k++) begin
      sh = (k == 0) ? 6'd63 : 6'($random(seed));
      a  = rand64();
      b  = rand64();
      foreach (bits[i]) begin
        issue_reg(bits[i], a, {b[63:6], sh});
        issue_imm(bits[i], a, sh);
      end
      foreach (adds[i]) issue_reg(adds[i], a, b);
      issue_imm(OP_UNSIGNED_SHIFT_LEFT_32, a, sh);
    end
  endtask

  task automatic test_clmul();
    xlen_t a;
    xlen_t b;
    cur_test = "clmul";
    repeat (3) begin
      a = rand64();
      b = rand64();
      issue_reg(OP_CARRY_LESS_MUL, a, b);
      issue_reg(OP_CARRY_LESS_MULH, a, b);
      issue_reg(OP_CARRY_LESS_MULR, a, b);
    end
  endtask

  task automatic test_stream();
    cur_test = "stream";
    issue_reg(OP_XNOR, rand64(), rand64());
    issue_reg(OP_CPOP, rand64(), rand64());
    // reserved funct7 under OP decodes to nothing
    issue_word(enc_r(OP, 7'b1111111, 3'b001), rand64(), rand64(), '0, 1'b1);
    issue_reg(OP_UNSIGNED_MAX, rand64(), rand64());
    issue_reg(OP_BYTE_REVERSE, rand64(), rand64());
  endtask

  initial begin
    arst_n = 1'b0;
    valid  = 1'b0;
    instr  = 32'h0;
    rs1    = '0;
    rs2    = '0;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;
    for (int t = 1; t <= 6; t++) run_test(t);
    $display("tests ok %0d, tests with errors %0d, check errors %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/bitmanip_pkg.sv
logic/bit_clz.sv
logic/bit_cnt.sv
logic/bitmanip_alu.sv
logic/bitmanip_decode_stage.sv
logic/bitmanip_execute_stage.sv
logic/bitmanip_unit.sv
dv/tb_clock.sv
dv/bitmanip_assertions.sv
dv/bitmanip_tb.sv

//--- Makefile
# Verilator build and run for the bitmanip unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module bitmanip_tb -Mdir obj_dir
	./obj_dir/Vbitmanip_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
